// File: flist.f
rtl/rv_core_pkg.sv
rtl/core_sequencer.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/rv_core_top.sv
verif/clock_gen.sv
verif/tb_rv_core.sv

// File: rtl/core_sequencer.sv
/* Multicycle control sequencer */

`timescale 1ns/1ps

module core_sequencer
    import rv_core_pkg::*;
(
    input  logic clk,
    input  logic i_rst,
    input  logic i_instr_valid,
    output logic o_ready,
    output logic o_ir_load,
    output logic o_opnd_load,
    output logic o_exec
);

    // One-hot state encoding.
    typedef enum logic [3:0] {
        S_IDLE   = 4'b0001,
        S_DECODE = 4'b0010,
        S_READ   = 4'b0100,
        S_EXEC   = 4'b1000
    } state_e;

    state_e s_state;
    state_e s_next;

    // ---------------------------------------------------------------------
    // State register.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            s_state <= S_IDLE;
        end else begin
            s_state <= s_next;
        end
    end

    // Next state.
    always_comb begin
        s_next = s_state;
        case (s_state)
            S_IDLE:   if (i_instr_valid) s_next = S_DECODE;
            S_DECODE: s_next = S_READ;
            S_READ:   s_next = S_EXEC;
            S_EXEC:   s_next = S_IDLE;
            default:  s_next = S_IDLE;
        endcase
    end

    // ---------------------------------------------------------------------
    // Stage enables, each for one cycle.
    // ---------------------------------------------------------------------
    assign o_ready     = (s_state == S_IDLE);
    assign o_ir_load   = (s_state == S_IDLE) && i_instr_valid;
    assign o_opnd_load = (s_state == S_DECODE);
    assign o_exec      = (s_state == S_READ);

    a_state_onehot: assert property (@(posedge clk) disable iff (i_rst)
        $onehot(s_state));

    a_enables_exclusive: assert property (@(posedge clk) disable iff (i_rst)
        $onehot0({o_ir_load, o_opnd_load, o_exec}));

    // Source must wait for ready.
    a_valid_when_busy: assert property (@(posedge clk) disable iff (i_rst)
        i_instr_valid |-> o_ready)
        else $error("i_instr_valid raised while core busy");

endmodule

// File: rtl/execute_unit.sv
/* ALU, writeback select and PC */

`timescale 1ns/1ps

module execute_unit
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_exec,
    input  dec_op_t         i_dec,
    input  opnd_t           i_opnd,
    output logic            o_wb_en,
    output logic            o_wb_valid,
    output wb_result_t      o_wb,
    output logic            o_illegal,
    output logic [XLEN-1:0] o_pc
);

    logic [XLEN-1:0] s_src1;
    logic [XLEN-1:0] s_src2;
    logic [5:0]      s_shamt;
    logic [XLEN-1:0] s_alu_result;
    logic [XLEN-1:0] s_link;
    logic [XLEN-1:0] s_next_pc;
    logic [XLEN-1:0] s_wb_data;

    // Second operand select.
    assign s_src1  = i_opnd.rs1_val;
    assign s_src2  = i_dec.src2_is_imm ? i_dec.imm : i_opnd.rs2_val;
    assign s_shamt = s_src2[5:0];

    // ---------------------------------------------------------------------
    // ALU.
    // ---------------------------------------------------------------------
    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:  s_alu_result = s_src1 + s_src2;
            ALU_SUB:  s_alu_result = s_src1 - s_src2;
            ALU_AND:  s_alu_result = s_src1 & s_src2;
            ALU_OR:   s_alu_result = s_src1 | s_src2;
            ALU_XOR:  s_alu_result = s_src1 ^ s_src2;
            ALU_SLL:  s_alu_result = s_src1 << s_shamt;
            ALU_SRL:  s_alu_result = s_src1 >> s_shamt;
            ALU_SRA:  s_alu_result = $signed(s_src1) >>> s_shamt;
            ALU_SLT:  s_alu_result = {{(XLEN-1){1'b0}}, $signed(s_src1) < $signed(s_src2)};
            ALU_SLTU: s_alu_result = {{(XLEN-1){1'b0}}, s_src1 < s_src2};
            default:  s_alu_result = '0;
        endcase
    end

    // ---------------------------------------------------------------------
    // Next PC and result mux.
    // ---------------------------------------------------------------------
    assign s_link    = o_pc + PC_STEP;
    assign s_next_pc = i_dec.is_jump ? (o_pc + i_dec.imm) : s_link;

    always_comb begin
        case (i_dec.wb_sel)
            WB_ALU:   s_wb_data = s_alu_result;
            WB_UPPER: s_wb_data = i_dec.imm;
            WB_LINK:  s_wb_data = s_link;
            default:  s_wb_data = s_alu_result;
        endcase
    end

    // Strobes and PC.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_pc       <= '0;
            o_wb_en    <= 1'b0;
            o_wb_valid <= 1'b0;
            o_illegal  <= 1'b0;
        end else begin
            o_wb_en    <= i_exec && !i_dec.illegal && i_dec.reg_write;
            o_wb_valid <= i_exec && !i_dec.illegal;
            o_illegal  <= i_exec && i_dec.illegal;
            if (i_exec) begin
                o_pc <= s_next_pc;
            end
        end
    end

    // Retired result.
    always_ff @(posedge clk) begin
        if (i_exec) begin
            o_wb.rd      <= i_dec.rd;
            o_wb.data    <= s_wb_data;
            o_wb.next_pc <= s_next_pc;
        end
    end

    // Each executed instruction ends in exactly one of the two pulses.
    a_one_outcome: assert property (@(posedge clk) disable iff (i_rst)
        i_exec |=> $onehot({o_wb_valid, o_illegal}));

endmodule

// File: rtl/instr_decoder.sv
/* Instruction register and decode */

`timescale 1ns/1ps

module instr_decoder
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_ir_load,
    input  instr_word_u i_instr,
    output dec_op_t     o_dec
);

    instr_word_u     s_ir;
    logic            s_f7_base;
    logic            s_f7_alt;
    logic [XLEN-1:0] s_imm_i;
    logic [XLEN-1:0] s_imm_u;
    logic [XLEN-1:0] s_imm_j;

    // Instruction register.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            s_ir <= INSTR_NOP;
        end else if (i_ir_load) begin
            s_ir <= i_instr;
        end
    end

    // ---------------------------------------------------------------------
    // Immediate extension per format.
    // ---------------------------------------------------------------------
    assign s_imm_i = {{(XLEN-12){s_ir.i.imm[11]}}, s_ir.i.imm};
    assign s_imm_u = {{(XLEN-32){s_ir.u.imm[19]}}, s_ir.u.imm, 12'b0};
    assign s_imm_j = {{(XLEN-21){s_ir.j.imm_20}}, s_ir.j.imm_20, s_ir.j.imm_19_12,
                      s_ir.j.imm_11, s_ir.j.imm_10_1, 1'b0};

    assign s_f7_base = (s_ir.r.funct7 == F7_BASE);
    assign s_f7_alt  = (s_ir.r.funct7 == F7_ALT);

    // ---------------------------------------------------------------------
    // Decode.
    // ---------------------------------------------------------------------
    always_comb begin
        o_dec           = '0;
        o_dec.alu_op    = ALU_ADD;
        o_dec.wb_sel    = WB_ALU;
        o_dec.rd        = s_ir.r.rd;
        o_dec.rs1       = s_ir.r.rs1;
        o_dec.rs2       = s_ir.r.rs2;
        o_dec.reg_write = 1'b1;

        case (s_ir.r.opcode)
            OPC_OP: begin
                case (s_ir.r.funct3)
                    F3_ADD_SUB: o_dec.alu_op = s_f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     o_dec.alu_op = ALU_SLL;
                    F3_SLT:     o_dec.alu_op = ALU_SLT;
                    F3_SLTU:    o_dec.alu_op = ALU_SLTU;
                    F3_XOR:     o_dec.alu_op = ALU_XOR;
                    F3_SRL_SRA: o_dec.alu_op = s_f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      o_dec.alu_op = ALU_OR;
                    F3_AND:     o_dec.alu_op = ALU_AND;
                endcase
                // Only sub and sra take the alternate funct7.
                if (!(s_f7_base || (s_f7_alt && (s_ir.r.funct3 == F3_ADD_SUB ||
                                                 s_ir.r.funct3 == F3_SRL_SRA)))) begin
                    o_dec.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                o_dec.src2_is_imm = 1'b1;
                o_dec.imm         = s_imm_i;
                case (s_ir.i.funct3)
                    F3_ADD_SUB: o_dec.alu_op = ALU_ADD;
                    F3_SLT:     o_dec.alu_op = ALU_SLT;
                    F3_SLTU:    o_dec.alu_op = ALU_SLTU;
                    F3_XOR:     o_dec.alu_op = ALU_XOR;
                    F3_OR:      o_dec.alu_op = ALU_OR;
                    F3_AND:     o_dec.alu_op = ALU_AND;
                    F3_SLL: begin
                        o_dec.alu_op  = ALU_SLL;
                        o_dec.illegal = (s_ir.i.imm[11:6] != 6'b0);
                    end
                    F3_SRL_SRA: begin
                        if (s_ir.i.imm[11:6] == F6_SRAI) begin
                            o_dec.alu_op = ALU_SRA;
                        end else begin
                            o_dec.alu_op  = ALU_SRL;
                            o_dec.illegal = (s_ir.i.imm[11:6] != 6'b0);
                        end
                    end
                endcase
            end
            OPC_LUI: begin
                o_dec.wb_sel = WB_UPPER;
                o_dec.imm    = s_imm_u;
            end
            OPC_JAL: begin
                o_dec.is_jump = 1'b1;
                o_dec.wb_sel  = WB_LINK;
                o_dec.imm     = s_imm_j;
            end
            default: o_dec.illegal = 1'b1;
        endcase

        if (o_dec.illegal) begin
            o_dec.reg_write = 1'b0;
        end
    end

endmodule

// File: rtl/register_file.sv
/* Register file and operand registers */

`timescale 1ns/1ps

module register_file
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_opnd_load,
    input  dec_op_t               i_dec,
    input  logic                  i_wb_en,
    input  logic [REG_ADDR_W-1:0] i_wb_rd,
    input  logic [XLEN-1:0]       i_wb_data,
    output opnd_t                 o_opnd
);

    logic [XLEN-1:0] s_regs [NUM_REGS];

    // ---------------------------------------------------------------------
    // Architectural registers.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                s_regs[i] <= '0;
            end
        end else if (i_wb_en && (i_wb_rd != '0)) begin
            // x0 is hardwired, so its writes are dropped here.
            s_regs[i_wb_rd] <= i_wb_data;
        end
    end

    // ---------------------------------------------------------------------
    // Operand registers.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_opnd_load) begin
            o_opnd.rs1_val <= s_regs[i_dec.rs1];
            o_opnd.rs2_val <= s_regs[i_dec.rs2];
        end
    end

    // Operands sourced from x0 read as zero.
    a_x0_rs1_zero: assert property (@(posedge clk) disable iff (i_rst)
        (i_opnd_load && (i_dec.rs1 == '0)) |=> (o_opnd.rs1_val == '0));

    a_x0_rs2_zero: assert property (@(posedge clk) disable iff (i_rst)
        (i_opnd_load && (i_dec.rs2 == '0)) |=> (o_opnd.rs2_val == '0));

endmodule

// File: rtl/rv_core_pkg.sv
/* RV64 core shared definitions */

package rv_core_pkg;

    // ---------------------------------------------------------------------
    // Widths and sizes.
    // ---------------------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int INSTR_W    = 32;

    localparam logic [XLEN-1:0]    PC_STEP    = 64'd4;
    localparam logic [INSTR_W-1:0] INSTR_NOP  = 32'h0000_0013;  // addi x0, x0, 0

    // Major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Function codes.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [5:0] F6_SRAI    = 6'b010000;  // RV64 shifts take a 6-bit shamt

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_UPPER, WB_LINK
    } wb_sel_e;

    // ---------------------------------------------------------------------
    // Instruction field layouts.
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
        j_fmt_t j;
    } instr_word_u;

    // One decoded instruction.
    typedef struct packed {
        alu_op_e                alu_op;
        wb_sel_e                wb_sel;
        logic                   src2_is_imm;
        logic                   is_jump;
        logic                   reg_write;
        logic                   illegal;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [XLEN-1:0]        imm;
    } dec_op_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       next_pc;
    } wb_result_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } opnd_t;

endpackage

// File: rtl/rv_core_top.sv
/* RV64 multicycle core top */

`timescale 1ns/1ps

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_instr_valid,
    input  instr_word_u     i_instr,
    output logic            o_ready,
    output logic            o_wb_valid,
    output wb_result_t      o_wb,
    output logic            o_illegal,
    output logic [XLEN-1:0] o_pc
);

    // ---------------------------------------------------------------------
    // Internal nets.
    // ---------------------------------------------------------------------
    logic    s_ir_load;
    logic    s_opnd_load;
    logic    s_exec;
    logic    s_wb_en;
    dec_op_t s_dec;
    opnd_t   s_opnd;

    // Control.
    core_sequencer SEQ (
        .clk           ( clk           ),
        .i_rst         ( i_rst         ),
        .i_instr_valid ( i_instr_valid ),
        .o_ready       ( o_ready       ),
        .o_ir_load     ( s_ir_load     ),
        .o_opnd_load   ( s_opnd_load   ),
        .o_exec        ( s_exec        )
    );

    instr_decoder DEC (
        .clk       ( clk       ),
        .i_rst     ( i_rst     ),
        .i_ir_load ( s_ir_load ),
        .i_instr   ( i_instr   ),
        .o_dec     ( s_dec     )
    );

    // Register write comes back from the retired result.
    register_file REG_FILE (
        .clk         ( clk         ),
        .i_rst       ( i_rst       ),
        .i_opnd_load ( s_opnd_load ),
        .i_dec       ( s_dec       ),
        .i_wb_en     ( s_wb_en     ),
        .i_wb_rd     ( o_wb.rd     ),
        .i_wb_data   ( o_wb.data   ),
        .o_opnd      ( s_opnd      )
    );

    execute_unit EXU (
        .clk        ( clk        ),
        .i_rst      ( i_rst      ),
        .i_exec     ( s_exec     ),
        .i_dec      ( s_dec      ),
        .i_opnd     ( s_opnd     ),
        .o_wb_en    ( s_wb_en    ),
        .o_wb_valid ( o_wb_valid ),
        .o_wb       ( o_wb       ),
        .o_illegal  ( o_illegal  ),
        .o_pc       ( o_pc       )
    );

endmodule

// File: verif/clock_gen.sv
/* Testbench clock and reset */

`timescale 1ns/1ps

module clock_gen (
    output logic o_clk,
    output logic o_rst
);

    // 20 ns period.
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // Reset held over three rising edges.
    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        #1 o_rst = 1'b0;
    end

endmodule

// File: verif/tb_rv_core.sv
/* RV64 multicycle core testbench */

`timescale 1ns/1ps

module tb_rv_core
    import rv_core_pkg::*;
();

    typedef struct {
        string       name;
        instr_word_u instr;
        logic        exp_illegal;
        wb_result_t  exp_wb;
    } test_vec_t;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    instr_word_u     instr;
    logic            ready;
    logic            wb_valid;
    wb_result_t      wb;
    logic            illegal;
    logic [XLEN-1:0] pc;

    test_vec_t tests[$];
    int        errors      = 0;
    int        passed      = 0;
    int        failed      = 0;
    int        cycles      = 0;
    int        cycle_limit = 0;

    clock_gen CLK_GEN (
        .o_clk ( clk ),
        .o_rst ( rst )
    );

    rv_core_top UUT (
        .clk           ( clk         ),
        .i_rst         ( rst         ),
        .i_instr_valid ( instr_valid ),
        .i_instr       ( instr       ),
        .o_ready       ( ready       ),
        .o_wb_valid    ( wb_valid    ),
        .o_wb          ( wb          ),
        .o_illegal     ( illegal     ),
        .o_pc          ( pc          )
    );

    // -------------------------------------------------------------------
    // Instruction encoders.
    // -------------------------------------------------------------------
    function automatic instr_word_u op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        instr_word_u w;
        w.r = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return w;
    endfunction

    function automatic instr_word_u imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        instr_word_u w;
        w.i = '{imm, rs1, f3, rd, OPC_OP_IMM};
        return w;
    endfunction

    function automatic instr_word_u lui_word(input logic [19:0] imm, input logic [4:0] rd);
        instr_word_u w;
        w.u = '{imm, rd, OPC_LUI};
        return w;
    endfunction

    // Offset is in bytes and the format drops bit 0.
    function automatic instr_word_u jal_word(input logic [20:0] off, input logic [4:0] rd);
        instr_word_u w;
        w.j = '{off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
        return w;
    endfunction

    task automatic push_test(input string name, input instr_word_u w, input logic ill,
                             input logic [4:0] rd, input logic [XLEN-1:0] data,
                             input logic [XLEN-1:0] npc);
        test_vec_t v;
        v.name        = name;
        v.instr       = w;
        v.exp_illegal = ill;
        v.exp_wb      = '{rd, data, npc};
        tests.push_back(v);
    endtask

    // x1 = 5, x2 = -3, x3 = 0x12345000, x4 = 0xffffffff80000000.
    task automatic build_table();
        push_test("addi", imm_word(12'd5, 5'd0, F3_ADD_SUB, 5'd1), 0, 5'd1, 64'd5, 64'd4);
        push_test("addi neg", imm_word(12'hffd, 5'd0, F3_ADD_SUB, 5'd2), 0, 5'd2,
                  64'hffff_ffff_ffff_fffd, 64'd8);
        push_test("lui", lui_word(20'h12345, 5'd3), 0, 5'd3, 64'h1234_5000, 64'd12);
        push_test("lui neg", lui_word(20'h80000, 5'd4), 0, 5'd4,
                  64'hffff_ffff_8000_0000, 64'd16);
        push_test("add", op_word(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd5), 0, 5'd5, 64'd2, 64'd20);
        push_test("sub", op_word(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd6), 0, 5'd6, 64'd8, 64'd24);
        push_test("xor", op_word(F7_BASE, 5'd2, 5'd3, F3_XOR, 5'd7), 0, 5'd7,
                  64'hffff_ffff_edcb_affd, 64'd28);
        push_test("and", op_word(F7_BASE, 5'd2, 5'd4, F3_AND, 5'd8), 0, 5'd8,
                  64'hffff_ffff_8000_0000, 64'd32);
        push_test("or", op_word(F7_BASE, 5'd1, 5'd3, F3_OR, 5'd9), 0, 5'd9,
                  64'h1234_5005, 64'd36);
        push_test("sll", op_word(F7_BASE, 5'd1, 5'd1, F3_SLL, 5'd10), 0, 5'd10, 64'ha0, 64'd40);
        push_test("sra", op_word(F7_ALT, 5'd1, 5'd4, F3_SRL_SRA, 5'd11), 0, 5'd11,
                  64'hffff_ffff_fc00_0000, 64'd44);
        push_test("srl", op_word(F7_BASE, 5'd1, 5'd4, F3_SRL_SRA, 5'd12), 0, 5'd12,
                  64'h07ff_ffff_fc00_0000, 64'd48);
        push_test("slt", op_word(F7_BASE, 5'd1, 5'd2, F3_SLT, 5'd13), 0, 5'd13, 64'd1, 64'd52);
        push_test("sltu", op_word(F7_BASE, 5'd1, 5'd2, F3_SLTU, 5'd14), 0, 5'd14, 64'd0, 64'd56);
        push_test("slti", imm_word(12'hffe, 5'd2, F3_SLT, 5'd15), 0, 5'd15, 64'd1, 64'd60);
        push_test("sltiu", imm_word(12'hfff, 5'd1, F3_SLTU, 5'd16), 0, 5'd16, 64'd1, 64'd64);
        push_test("xori", imm_word(12'hfff, 5'd1, F3_XOR, 5'd17), 0, 5'd17,
                  64'hffff_ffff_ffff_fffa, 64'd68);
        push_test("slli", imm_word(12'd40, 5'd1, F3_SLL, 5'd18), 0, 5'd18,
                  64'h0000_0500_0000_0000, 64'd72);
        push_test("srai", imm_word(12'h401, 5'd2, F3_SRL_SRA, 5'd19), 0, 5'd19,
                  64'hffff_ffff_ffff_fffe, 64'd76);
        // Write to x0 still retires, then x0 must read back as zero.
        push_test("add x0", op_word(F7_BASE, 5'd1, 5'd1, F3_ADD_SUB, 5'd0), 0, 5'd0,
                  64'd10, 64'd80);
        push_test("read x0", op_word(F7_BASE, 5'd1, 5'd0, F3_ADD_SUB, 5'd20), 0, 5'd20,
                  64'd5, 64'd84);
        push_test("jal fwd", jal_word(21'd16, 5'd21), 0, 5'd21, 64'd88, 64'd100);
        push_test("jal back", jal_word(21'h1f_ffd8, 5'd22), 0, 5'd22, 64'd104, 64'd60);
        // ld x1, 0(x0) is not supported.
        push_test("illegal", 32'h0000_3083, 1, 5'd0, 64'd0, 64'd64);
        push_test("x1 kept", op_word(F7_BASE, 5'd0, 5'd1, F3_ADD_SUB, 5'd23), 0, 5'd23,
                  64'd5, 64'd68);
    endtask

    // -------------------------------------------------------------------
    // Compare tasks.
    // -------------------------------------------------------------------
    task automatic check_flag(input string sig, input logic act, input logic exp);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, sig, act, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [XLEN-1:0] act, input logic [XLEN-1:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: o_pc = %h, expected %h", $time, act, exp);
            errors++;
        end
    endtask

    task automatic check_wb(input wb_result_t act, input wb_result_t exp);
        if (act.rd !== exp.rd) begin
            $display("CHECK FAILED at %0t: o_wb.rd = %0d, expected %0d", $time, act.rd, exp.rd);
            errors++;
        end
        if (act.data !== exp.data) begin
            $display("CHECK FAILED at %0t: o_wb.data = %h, expected %h",
                     $time, act.data, exp.data);
            errors++;
        end
        if (act.next_pc !== exp.next_pc) begin
            $display("CHECK FAILED at %0t: o_wb.next_pc = %h, expected %h",
                     $time, act.next_pc, exp.next_pc);
            errors++;
        end
    endtask

    // Inputs change and outputs are sampled 1 ns after the edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before) begin
            passed++;
            $display("Test %-10s ok", name);
        end else begin
            failed++;
            $display("Test %-10s FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic check_reset();
        int err_before;
        err_before = errors;
        check_flag("o_ready", ready, 1'b1);
        check_flag("o_wb_valid", wb_valid, 1'b0);
        check_flag("o_illegal", illegal, 1'b0);
        check_pc(pc, '0);
        report("reset", err_before);
    endtask

    task automatic run_test(input int idx);
        test_vec_t v;
        int        lat;
        int        err_before;
        v          = tests[idx];
        err_before = errors;
        repeat ($urandom_range(0, 3)) next_cycle();
        while (!ready) next_cycle();
        instr_valid = 1'b1;
        instr       = v.instr;
        next_cycle();
        instr_valid = 1'b0;
        // Edges counted from the accepting edge.
        lat = 1;
        while (!(wb_valid || illegal) && lat < 8) begin
            check_flag("o_ready", ready, 1'b0);
            next_cycle();
            lat++;
        end
        if (!(wb_valid || illegal)) begin
            $display("Test %s: no writeback or illegal pulse after %0d cycles", v.name, lat);
            errors++;
        end else begin
            if (lat != 3) begin
                $display("CHECK FAILED at %0t: writeback latency = %0d, expected 3", $time, lat);
                errors++;
            end
            check_flag("o_wb_valid", wb_valid, !v.exp_illegal);
            check_flag("o_illegal", illegal, v.exp_illegal);
            check_flag("o_ready", ready, 1'b0);
            if (!v.exp_illegal) begin
                check_wb(wb, v.exp_wb);
            end
            check_pc(pc, v.exp_wb.next_pc);
            // Pulse lasts one cycle, then the core is ready again.
            next_cycle();
            check_flag("o_wb_valid", wb_valid, 1'b0);
            check_flag("o_illegal", illegal, 1'b0);
            check_flag("o_ready", ready, 1'b1);
        end
        report(v.name, err_before);
    endtask

    // -------------------------------------------------------------------
    // Run control.
    // -------------------------------------------------------------------
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(32'hdd46d2c6));
        build_table();
        cycle_limit = tests.size() * 8 + 20;
        @(negedge rst);
        check_reset();
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end
        $display("Summary: %0d tests, %0d ok, %0d failed, %0d check errors",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
